/* project.f */
hdl/backend_pkg.sv
hdl/reg_file.sv
hdl/inst_decoder.sv
hdl/alu_execute.sv
hdl/writeback_commit.sv
hdl/backend_top.sv
bench/clock_gen.sv
bench/backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run backend_tb with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module backend_tb -f project.f -o backend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/backend_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* bench/backend_tb.sv */
`default_nettype none

module backend_tb
    import backend_pkg::*;
();

    localparam int QUEUE_DEPTH = 8;
    localparam int MAX_PROG    = 64;
    localparam int NUM_TESTS   = 6;
    localparam int TOTAL_LEN   = 60 + 40 + 3 * 50;
    localparam int CYCLE_LIMIT = 4 * TOTAL_LEN + 200 * NUM_TESTS;
    localparam logic [XLEN-1:0] PROG_BASE = 32'h0000_1000;

    typedef struct packed {
        logic [XLEN-1:0]        pc;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   we;
        logic [XLEN-1:0]        data;
    } commit_rec_t;

    logic                   clk;
    logic                   reset_i;
    logic                   fetch_valid_i;
    fetch_entry_t           fetch_entry_i;
    logic [CREDIT_W-1:0]    credit_return_o;
    logic                   redirect_valid_o;
    logic [XLEN-1:0]        redirect_pc_o;
    logic                   commit_valid_o;
    logic [XLEN-1:0]        commit_pc_o;
    logic [REG_ADDR_W-1:0]  commit_rd_o;
    logic                   commit_we_o;
    logic [XLEN-1:0]        commit_data_o;

    logic [XLEN-1:0]  prog_mem [MAX_PROG];
    commit_rec_t      exp_commits [$];
    logic [XLEN-1:0]  exp_targets [$];
    commit_rec_t      want_rec;
    logic [XLEN-1:0]  want_target;
    integer           seed;
    int               errors;
    int               test_errors;
    int               tests_failed;
    int               commit_count;
    int               redirect_count;
    int               cycles = 0;

    clock_gen #(.PERIOD(20)) u_clock_gen (.clk_o(clk));

    backend_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) uut (
        .clk,
        .reset_i,
        .fetch_valid_i,
        .fetch_entry_i,
        .credit_return_o,
        .redirect_valid_o,
        .redirect_pc_o,
        .commit_valid_o,
        .commit_pc_o,
        .commit_rd_o,
        .commit_we_o,
        .commit_data_o
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [XLEN-1:0] encode_inst(input logic [3:0] op,
                                                   input logic [4:0] rd,
                                                   input logic [4:0] rs1,
                                                   input logic [4:0] rs2,
                                                   input logic [12:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    // runs the program in order and lists what must retire
    function automatic void build_expected(input int len);
        logic [XLEN-1:0]        regs [32];
        logic [XLEN-1:0]        inst;
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        logic [XLEN-1:0]        imm;
        logic [XLEN-1:0]        res;
        logic [3:0]             op;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   taken;
        commit_rec_t            rec;
        int                     idx;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        exp_commits.delete();
        exp_targets.delete();
        idx = 0;
        while (idx < len) begin
            inst  = prog_mem[idx];
            op    = inst[31:28];
            rd    = inst[27:23];
            a     = regs[inst[22:18]];
            b     = regs[inst[17:13]];
            imm   = {{19{inst[12]}}, inst[12:0]};
            pc    = PROG_BASE + 32'(idx * 4);
            res   = '0;
            taken = 1'b0;
            case (op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_SLL:  res = a << b[4:0];
                OP_SRL:  res = a >> b[4:0];
                OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_ADDI: res = a + imm;
                OP_LUI:  res = {inst[12:0], 19'd0};
                OP_BEQ:  taken = (a == b);
                OP_BNE:  taken = (a != b);
                default: res = '0;
            endcase
            rec.pc   = pc;
            rec.rd   = rd;
            rec.we   = !(op == OP_BEQ || op == OP_BNE) && (rd != '0);
            rec.data = res;
            exp_commits.push_back(rec);
            if (rec.we) begin
                regs[rd] = res;
            end
            if (taken) begin
                exp_targets.push_back(pc + (imm << 2));
                idx = idx + int'($signed(imm));
            end else begin
                idx++;
            end
        end
    endfunction

    task automatic random_alu_program();
        // load r1..r7 first so the ALU ops see real data
        for (int i = 1; i < 8; i++) begin
            prog_mem[2*i-2] = encode_inst(OP_LUI, 5'(i), 5'd0, 5'd0, 13'(rand_below(8192)));
            prog_mem[2*i-1] = encode_inst(OP_ADDI, 5'(i), 5'(i), 5'd0, 13'(rand_below(8192)));
        end
        for (int i = 14; i < 60; i++) begin
            prog_mem[i] = encode_inst(4'(rand_below(8)), 5'(rand_below(8)),
                                      5'(rand_below(8)), 5'(rand_below(8)),
                                      13'(rand_below(8192)));
        end
    endtask

    task automatic forwarding_chain_program();
        logic [REG_ADDR_W-1:0] rd_hist [40];
        logic [REG_ADDR_W-1:0] src;
        for (int i = 0; i < 40; i++) begin
            rd_hist[i] = 5'(rand_below(31) + 1);
            if (i < 2 || rand_below(4) == 0) begin
                prog_mem[i] = encode_inst(OP_LUI, rd_hist[i], 5'd0, 5'd0,
                                          13'(rand_below(8192)));
            end else begin
                // one or two back to hit the ex or the wb bypass
                src = rd_hist[i - 1 - rand_below(2)];
                prog_mem[i] = encode_inst(OP_ADDI, rd_hist[i], src, 5'd0,
                                          13'(rand_below(8192)));
            end
        end
    endtask

    task automatic branch_mix_program();
        int pick;
        // small values in few registers so compares often match
        for (int i = 0; i < 4; i++) begin
            prog_mem[i] = encode_inst(OP_ADDI, 5'(i + 1), 5'd0, 5'd0, 13'(rand_below(3)));
        end
        for (int i = 4; i < 50; i++) begin
            pick = rand_below(10);
            if (pick < 4) begin
                prog_mem[i] = encode_inst((pick < 2) ? OP_BEQ : OP_BNE, 5'd0,
                                          5'(rand_below(5)), 5'(rand_below(5)),
                                          13'(rand_below(4) + 1));
            end else if (pick < 7) begin
                prog_mem[i] = encode_inst(OP_ADDI, 5'(rand_below(4) + 1), 5'(rand_below(5)),
                                          5'd0, 13'(rand_below(3) - 1));
            end else begin
                prog_mem[i] = encode_inst(4'(rand_below(5)), 5'(rand_below(5)),
                                          5'(rand_below(5)), 5'(rand_below(5)), 13'd0);
            end
        end
    endtask

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_idle();
        if (commit_valid_o !== 1'b0) begin
            $display("FAIL commit_valid_o: got %h expected 0", commit_valid_o);
            count_error();
        end
        if (redirect_valid_o !== 1'b0) begin
            $display("FAIL redirect_valid_o: got %h expected 0", redirect_valid_o);
            count_error();
        end
        if (credit_return_o !== '0) begin
            $display("FAIL credit_return_o: got %h expected 0", credit_return_o);
            count_error();
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0s: %0d commits, %0d redirects, %0d errors",
                 name, commit_count, redirect_count, test_errors);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_i = 1'b1;
        fetch_valid_i = 1'b0;
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
    endtask

    task automatic reset_state_test();
        test_errors = 0;
        reset_i = 1'b1;
        fetch_valid_i = 1'b0;
        for (int i = 0; i < 24; i++) begin
            @(negedge clk);
            if (i == 15) begin
                reset_i = 1'b0;
            end
            check_idle();
        end
        finish_test("reset_state");
    endtask

    // fetch model sending one entry per cycle while a credit is held
    task automatic run_program(input string name, input int len);
        int credits;
        int fetch_idx;
        int sent;
        int returned;
        int quiet;
        int want_commits;
        int want_redirects;
        build_expected(len);
        want_commits = exp_commits.size();
        want_redirects = exp_targets.size();
        apply_reset();
        test_errors = 0;
        commit_count = 0;
        redirect_count = 0;
        credits = QUEUE_DEPTH;
        fetch_idx = 0;
        sent = 0;
        returned = 0;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clk);
            credits += int'(credit_return_o);
            returned += int'(credit_return_o);
            if (credits > QUEUE_DEPTH) begin
                $display("error: fetch side holds %0d credits, more than the queue depth %0d",
                         credits, QUEUE_DEPTH);
                count_error();
            end
            fetch_valid_i = 1'b0;
            if (credits > 0 && fetch_idx < len) begin
                fetch_valid_i = 1'b1;
                fetch_entry_i.pc = PROG_BASE + 32'(fetch_idx * 4);
                fetch_entry_i.inst = prog_mem[fetch_idx];
                credits--;
                sent++;
                fetch_idx++;
            end
            // this cycle's push gets dropped by the flush
            if (redirect_valid_o) begin
                fetch_idx = int'((redirect_pc_o - PROG_BASE) >> 2);
            end
            if (fetch_idx >= len && !fetch_valid_i && credit_return_o == '0 &&
                !commit_valid_o) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (returned != sent) begin
            $display("error: %0d credits came back for %0d entries sent", returned, sent);
            count_error();
        end
        if (commit_count != want_commits) begin
            $display("error: %0d instructions retired, the reference path has %0d",
                     commit_count, want_commits);
            count_error();
        end
        if (redirect_count != want_redirects) begin
            $display("error: %0d redirects seen, the reference path takes %0d branches",
                     redirect_count, want_redirects);
            count_error();
        end
        finish_test(name);
    endtask

    always @(negedge clk) begin
        if (commit_valid_o) begin
            commit_count++;
            if (exp_commits.size() == 0) begin
                $display("error: pc %08h retired after the reference path ended", commit_pc_o);
                count_error();
            end else begin
                want_rec = exp_commits.pop_front();
                if (commit_pc_o !== want_rec.pc) begin
                    $display("FAIL commit_pc_o: got %08h expected %08h", commit_pc_o, want_rec.pc);
                    count_error();
                end
                if (commit_rd_o !== want_rec.rd) begin
                    $display("FAIL commit_rd_o: got %02h expected %02h", commit_rd_o, want_rec.rd);
                    count_error();
                end
                if (commit_we_o !== want_rec.we) begin
                    $display("FAIL commit_we_o: got %h expected %h", commit_we_o, want_rec.we);
                    count_error();
                end
                if (want_rec.we && commit_data_o !== want_rec.data) begin
                    $display("FAIL commit_data_o: got %08h expected %08h",
                             commit_data_o, want_rec.data);
                    count_error();
                end
            end
        end
        if (redirect_valid_o) begin
            redirect_count++;
            if (exp_targets.size() == 0) begin
                $display("error: redirect to %08h with no taken branch expected", redirect_pc_o);
                count_error();
            end else begin
                want_target = exp_targets.pop_front();
                if (redirect_pc_o !== want_target) begin
                    $display("FAIL redirect_pc_o: got %08h expected %08h",
                             redirect_pc_o, want_target);
                    count_error();
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        seed = 74502;
        errors = 0;
        test_errors = 0;
        tests_failed = 0;
        commit_count = 0;
        redirect_count = 0;
        reset_i = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_entry_i = '0;
        reset_state_test();
        random_alu_program();
        run_program("alu_reg_reg", 60);
        forwarding_chain_program();
        run_program("imm_forwarding", 40);
        for (int t = 0; t < 3; t++) begin
            branch_mix_program();
            run_program($sformatf("branches_%0d", t), 50);
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`default_nettype none

module clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* hdl/backend_top.sv */
`default_nettype none

module backend_top
    import backend_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset_i,

    // from the instruction buffer
    input  logic                   fetch_valid_i,
    input  fetch_entry_t           fetch_entry_i,
    output logic [CREDIT_W-1:0]    credit_return_o,

    // to fetch
    output logic                   redirect_valid_o,
    output logic [XLEN-1:0]        redirect_pc_o,

    // retired instructions
    output logic                   commit_valid_o,
    output logic [XLEN-1:0]        commit_pc_o,
    output logic [REG_ADDR_W-1:0]  commit_rd_o,
    output logic                   commit_we_o,
    output logic [XLEN-1:0]        commit_data_o
);

    exec_op_t               decoded;
    result_t                ex_result;
    result_t                wb_result;
    reg_write_t             rf_write;
    logic [REG_ADDR_W-1:0]  rs1_addr;
    logic [REG_ADDR_W-1:0]  rs2_addr;
    logic [XLEN-1:0]        rs1_data;
    logic [XLEN-1:0]        rs2_data;

    inst_decoder #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_inst_decoder (
        .clk,
        .reset_i,
        .fetch_valid_i,
        .fetch_entry_i,
        .flush_i(redirect_valid_o),
        .ex_fwd_i(ex_result),
        .wb_fwd_i(wb_result),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .decoded_o(decoded),
        .credit_return_o
    );

    reg_file u_reg_file (
        .clk,
        .reset_i,
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .write_i(rf_write)
    );

    alu_execute u_alu_execute (
        .clk,
        .reset_i,
        .decoded_i(decoded),
        .result_o(ex_result),
        .redirect_valid_o,
        .redirect_pc_o
    );

    writeback_commit u_writeback_commit (
        .clk,
        .reset_i,
        .result_i(ex_result),
        .fwd_o(wb_result),
        .reg_write_o(rf_write),
        .commit_valid_o,
        .commit_pc_o,
        .commit_rd_o,
        .commit_we_o,
        .commit_data_o
    );

endmodule

`default_nettype wire

/* hdl/writeback_commit.sv */
`default_nettype none

module writeback_commit
    import backend_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,

    input  result_t                result_i,

    output result_t                fwd_o,
    output reg_write_t             reg_write_o,

    output logic                   commit_valid_o,
    output logic [XLEN-1:0]        commit_pc_o,
    output logic [REG_ADDR_W-1:0]  commit_rd_o,
    output logic                   commit_we_o,
    output logic [XLEN-1:0]        commit_data_o
);

    result_t wb_q;

    always_ff @(posedge clk) begin
        wb_q <= result_i;
        if (reset_i) begin
            wb_q.valid <= 1'b0;
        end
    end

    assign fwd_o = wb_q;

    // regfile takes it at the end of this cycle
    assign reg_write_o.en   = wb_q.valid && wb_q.we;
    assign reg_write_o.addr = wb_q.rd;
    assign reg_write_o.data = wb_q.data;

    assign commit_valid_o = wb_q.valid;
    assign commit_pc_o    = wb_q.pc;
    assign commit_rd_o    = wb_q.rd;
    assign commit_we_o    = wb_q.we;
    assign commit_data_o  = wb_q.data;

endmodule

`default_nettype wire

/* hdl/alu_execute.sv */
`default_nettype none

module alu_execute
    import backend_pkg::*;
(
    input  logic             clk,
    input  logic             reset_i,

    input  exec_op_t         decoded_i,

    output result_t          result_o,
    output logic             redirect_valid_o,
    output logic [XLEN-1:0]  redirect_pc_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    exec_op_t              ex_q;
    logic [XLEN-1:0]       alu_out;
    logic [SHAMT_W-1:0]    shamt;
    logic                  operands_equal;
    logic                  branch_taken;

    // no enable, a bubble simply flows in
    always_ff @(posedge clk) begin
        ex_q <= decoded_i;
        if (reset_i) begin
            ex_q.valid <= 1'b0;
        end
    end

    assign shamt          = ex_q.rs2_val[SHAMT_W-1:0];
    assign operands_equal = (ex_q.rs1_val == ex_q.rs2_val);

    always_comb begin
        case (ex_q.opcode)
            OP_ADD:  alu_out = ex_q.rs1_val + ex_q.rs2_val;
            OP_SUB:  alu_out = ex_q.rs1_val - ex_q.rs2_val;
            OP_AND:  alu_out = ex_q.rs1_val & ex_q.rs2_val;
            OP_OR:   alu_out = ex_q.rs1_val | ex_q.rs2_val;
            OP_XOR:  alu_out = ex_q.rs1_val ^ ex_q.rs2_val;
            OP_SLL:  alu_out = ex_q.rs1_val << shamt;
            OP_SRL:  alu_out = ex_q.rs1_val >> shamt;
            OP_SLT: begin
                alu_out = {{(XLEN - 1){1'b0}},
                           $signed(ex_q.rs1_val) < $signed(ex_q.rs2_val)};
            end
            OP_ADDI: alu_out = ex_q.rs1_val + ex_q.imm;
            // imm lands in bits 31:19
            OP_LUI:  alu_out = ex_q.imm << (XLEN - IMM_W);
            default: alu_out = '0;
        endcase
    end

    assign branch_taken = ex_q.valid &&
                          ((ex_q.opcode == OP_BEQ && operands_equal) ||
                           (ex_q.opcode == OP_BNE && !operands_equal));

    assign redirect_valid_o = branch_taken;
    assign redirect_pc_o    = ex_q.pc + (ex_q.imm << 2);

    always_comb begin
        result_o.valid = ex_q.valid;
        result_o.pc    = ex_q.pc;
        result_o.rd    = ex_q.rd;
        result_o.we    = ex_q.we;
        result_o.data  = alu_out;
    end

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
`default_nettype none

module inst_decoder
    import backend_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset_i,

    input  logic                   fetch_valid_i,
    input  fetch_entry_t           fetch_entry_i,
    input  logic                   flush_i,

    input  result_t                ex_fwd_i,
    input  result_t                wb_fwd_i,

    output logic [REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [REG_ADDR_W-1:0]  rs2_addr_o,
    input  logic [XLEN-1:0]        rs1_data_i,
    input  logic [XLEN-1:0]        rs2_data_i,

    output exec_op_t               decoded_o,
    output logic [CREDIT_W-1:0]    credit_return_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    fetch_entry_t           queue_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]       head_q;
    logic [PTR_W-1:0]       tail_q;
    logic [CREDIT_W-1:0]    count_q;
    logic [CREDIT_W-1:0]    credit_q;
    logic                   queue_empty;
    logic                   op_valid;
    logic                   writes_rd;
    fetch_entry_t           head_entry;
    inst_t                  head_inst;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // youngest producer wins; we is never set for rd 0
    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_ADDR_W-1:0]  addr,
        input logic [XLEN-1:0]        rf_data,
        input result_t                ex_res,
        input result_t                wb_res
    );
        if (ex_res.valid && ex_res.we && ex_res.rd == addr) begin
            return ex_res.data;
        end
        if (wb_res.valid && wb_res.we && wb_res.rd == addr) begin
            return wb_res.data;
        end
        return rf_data;
    endfunction

    assign queue_empty = (count_q == '0);
    assign head_entry  = queue_mem[head_q];
    assign head_inst   = inst_t'(head_entry.inst);
    assign op_valid    = !queue_empty && !flush_i;
    assign writes_rd   = head_inst.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                                  OP_SLL, OP_SRL, OP_SLT, OP_ADDI, OP_LUI};

    assign rs1_addr_o = head_inst.rs1;
    assign rs2_addr_o = head_inst.rs2;

    always_comb begin
        decoded_o.valid   = op_valid;
        decoded_o.opcode  = head_inst.opcode;
        decoded_o.pc      = head_entry.pc;
        decoded_o.rd      = head_inst.rd;
        decoded_o.we      = op_valid && writes_rd && (head_inst.rd != '0);
        decoded_o.rs1_val = pick_operand(head_inst.rs1, rs1_data_i, ex_fwd_i, wb_fwd_i);
        decoded_o.rs2_val = pick_operand(head_inst.rs2, rs2_data_i, ex_fwd_i, wb_fwd_i);
        decoded_o.imm     = {{(XLEN - IMM_W){head_inst.imm[IMM_W-1]}}, head_inst.imm};
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i && !flush_i) begin
            queue_mem[tail_q] <= fetch_entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            credit_q <= '0;
        end else if (flush_i) begin
            // everything queued plus the dropped push goes back
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            credit_q <= count_q + CREDIT_W'(fetch_valid_i);
        end else begin
            if (fetch_valid_i) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (!queue_empty) begin
                head_q <= ptr_inc(head_q);
            end
            count_q  <= count_q + CREDIT_W'(fetch_valid_i) - CREDIT_W'(!queue_empty);
            credit_q <= CREDIT_W'(!queue_empty);
        end
    end

    assign credit_return_o = credit_q;

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none

module reg_file
    import backend_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,

    input  logic [REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [XLEN-1:0]        rs1_data_o,
    output logic [XLEN-1:0]        rs2_data_o,

    input  reg_write_t             write_i
);

    logic [XLEN-1:0] regs_q [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (write_i.en && write_i.addr != '0) begin
            regs_q[write_i.addr] <= write_i.data;
        end
    end

    // r0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* hdl/backend_pkg.sv */
`default_nettype none

package backend_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;
    localparam int IMM_W      = 13;
    localparam int CREDIT_W   = 4;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SLT  = 4'd7,
        OP_ADDI = 4'd8,
        OP_LUI  = 4'd9,
        OP_BEQ  = 4'd10,
        OP_BNE  = 4'd11
    } opcode_e;

    // instruction word, opcode in the top nibble
    typedef struct packed {
        opcode_e                opcode;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [IMM_W-1:0]       imm;
    } inst_t;

    typedef struct packed {
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  inst;
    } fetch_entry_t;

    typedef struct packed {
        logic                   valid;
        opcode_e                opcode;
        logic [XLEN-1:0]        pc;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   we;
        logic [XLEN-1:0]        rs1_val;
        logic [XLEN-1:0]        rs2_val;
        logic [XLEN-1:0]        imm;
    } exec_op_t;

    typedef struct packed {
        logic                   valid;
        logic [XLEN-1:0]        pc;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   we;
        logic [XLEN-1:0]        data;
    } result_t;

    typedef struct packed {
        logic                   en;
        logic [REG_ADDR_W-1:0]  addr;
        logic [XLEN-1:0]        data;
    } reg_write_t;

endpackage

`default_nettype wire
